// File: Makefile
# Verilator build and run for the TLB testbench

VERILATOR   = verilator
FLAGS       = --assert --timing
BUILD_FLAGS = --binary
TOP         = tlb_tb
FILELIST    = tlb.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_MSG    = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int num_entries = 16
) (
    input  logic                          clk,
    input  logic                          reset,

    // search port 0
    input  logic [tlb_pkg::vpn2_w-1:0]    s0_vpn2,
    input  logic                          s0_odd_page,
    input  logic [tlb_pkg::asid_w-1:0]    s0_asid,
    output logic                          s0_found,
    output logic [$clog2(num_entries)-1:0] s0_index,
    output logic [tlb_pkg::pfn_w-1:0]     s0_pfn,
    output logic [tlb_pkg::cattr_w-1:0]   s0_c,
    output logic                          s0_d,
    output logic                          s0_v,

    // search port 1
    input  logic [tlb_pkg::vpn2_w-1:0]    s1_vpn2,
    input  logic                          s1_odd_page,
    input  logic [tlb_pkg::asid_w-1:0]    s1_asid,
    output logic                          s1_found,
    output logic [$clog2(num_entries)-1:0] s1_index,
    output logic [tlb_pkg::pfn_w-1:0]     s1_pfn,
    output logic [tlb_pkg::cattr_w-1:0]   s1_c,
    output logic                          s1_d,
    output logic                          s1_v,

    // write port
    input  logic                          we,
    input  logic [$clog2(num_entries)-1:0] w_index,
    input  logic [tlb_pkg::vpn2_w-1:0]    w_vpn2,
    input  logic [tlb_pkg::asid_w-1:0]    w_asid,
    input  logic                          w_g,
    input  logic [tlb_pkg::pfn_w-1:0]     w_pfn0,
    input  logic [tlb_pkg::cattr_w-1:0]   w_c0,
    input  logic                          w_d0,
    input  logic                          w_v0,
    input  logic [tlb_pkg::pfn_w-1:0]     w_pfn1,
    input  logic [tlb_pkg::cattr_w-1:0]   w_c1,
    input  logic                          w_d1,
    input  logic                          w_v1,

    // read port
    input  logic [$clog2(num_entries)-1:0] r_index,
    output logic [tlb_pkg::vpn2_w-1:0]    r_vpn2,
    output logic [tlb_pkg::asid_w-1:0]    r_asid,
    output logic                          r_g,
    output logic [tlb_pkg::pfn_w-1:0]     r_pfn0,
    output logic [tlb_pkg::cattr_w-1:0]   r_c0,
    output logic                          r_d0,
    output logic                          r_v0,
    output logic [tlb_pkg::pfn_w-1:0]     r_pfn1,
    output logic [tlb_pkg::cattr_w-1:0]   r_c1,
    output logic                          r_d1,
    output logic                          r_v1
);

    tlb_pkg::tlb_entry_t w_entry;
    tlb_pkg::tlb_entry_t r_entry;
    tlb_pkg::tlb_entry_t entries [num_entries];

    tlb_search_if #(.num_entries(num_entries)) s0_if ();
    tlb_search_if #(.num_entries(num_entries)) s1_if ();

    assign w_entry = '{
        vpn2:  w_vpn2,
        asid:  w_asid,
        g:     w_g,
        page0: '{pfn: w_pfn0, c: w_c0, d: w_d0, v: w_v0},
        page1: '{pfn: w_pfn1, c: w_c1, d: w_d1, v: w_v1}
    };

    tlb_entry_array #(.num_entries(num_entries)) u_array (
        .clk     (clk),
        .reset   (reset),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    assign r_vpn2 = r_entry.vpn2;
    assign r_asid = r_entry.asid;
    assign r_g    = r_entry.g;
    assign r_pfn0 = r_entry.page0.pfn;
    assign r_c0   = r_entry.page0.c;
    assign r_d0   = r_entry.page0.d;
    assign r_v0   = r_entry.page0.v;
    assign r_pfn1 = r_entry.page1.pfn;
    assign r_c1   = r_entry.page1.c;
    assign r_d1   = r_entry.page1.d;
    assign r_v1   = r_entry.page1.v;

    // port 0
    assign s0_if.vpn2     = s0_vpn2;
    assign s0_if.asid     = s0_asid;
    assign s0_if.page_sel = tlb_pkg::page_sel_e'(s0_odd_page);

    tlb_lookup #(.num_entries(num_entries)) u_lookup0 (
        .clk     (clk),
        .reset   (reset),
        .entries (entries),
        .sif     (s0_if.responder)
    );

    assign s0_found = s0_if.found;
    assign s0_index = s0_if.index;
    assign s0_pfn   = s0_if.page.pfn;
    assign s0_c     = s0_if.page.c;
    assign s0_d     = s0_if.page.d;
    assign s0_v     = s0_if.page.v;

    // port 1
    assign s1_if.vpn2     = s1_vpn2;
    assign s1_if.asid     = s1_asid;
    assign s1_if.page_sel = tlb_pkg::page_sel_e'(s1_odd_page);

    tlb_lookup #(.num_entries(num_entries)) u_lookup1 (
        .clk     (clk),
        .reset   (reset),
        .entries (entries),
        .sif     (s1_if.responder)
    );

    assign s1_found = s1_if.found;
    assign s1_index = s1_if.index;
    assign s1_pfn   = s1_if.page.pfn;
    assign s1_c     = s1_if.page.c;
    assign s1_d     = s1_if.page.d;
    assign s1_v     = s1_if.page.v;

endmodule

// File: hw/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array #(
    parameter int num_entries = 16
) (
    input  logic                         clk,
    input  logic                         reset,

    // write port
    input  logic                         we,
    input  logic [$clog2(num_entries)-1:0] w_index,
    input  tlb_pkg::tlb_entry_t          w_entry,

    // read port
    input  logic [$clog2(num_entries)-1:0] r_index,
    output tlb_pkg::tlb_entry_t          r_entry,

    // every entry, for the lookup ports
    output tlb_pkg::tlb_entry_t          entries [num_entries]
);

    // entry registers, no reset
    // contents stay undefined until software writes them
    always_ff @(posedge clk) begin
        if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    // read is combinational
    // a write in the same cycle shows up after the edge
    always_comb begin
        r_entry = entries[r_index];
    end

    // a write needs a known index inside the array
    a_w_index_range: assert property (
        @(posedge clk) disable iff (reset)
        we |-> (!$isunknown(w_index) && int'(w_index) < num_entries)
    ) else $error("tlb write index %0d unknown or out of range", w_index);

endmodule

// File: hw/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup #(
    parameter int num_entries = 16
) (
    input  logic                clk,
    input  logic                reset,

    input  tlb_pkg::tlb_entry_t entries [num_entries],

    tlb_search_if.responder     sif
);

    localparam int idx_w  = $clog2(num_entries);
    localparam int page_w = $bits(tlb_pkg::tlb_page_t);

    logic [num_entries-1:0] match;
    tlb_pkg::tlb_page_t     sel_page [num_entries];
    logic [idx_w-1:0]       hit_index;
    logic [page_w-1:0]      hit_page;

    // per-entry comparator and half page pick
    for (genvar i = 0; i < num_entries; i++) begin : g_entry
        logic vpn_eq;
        logic asid_ok;

        assign vpn_eq   = (entries[i].vpn2 == sif.vpn2);
        // global entries ignore the asid
        assign asid_ok  = (entries[i].asid == sif.asid) || entries[i].g;
        assign match[i] = vpn_eq && asid_ok;

        assign sel_page[i] = (sif.page_sel == tlb_pkg::page_odd) ?
                             entries[i].page1 : entries[i].page0;
    end

    // and-or encoder, at most one match is expected
    always_comb begin
        hit_index = '0;
        for (int i = 0; i < num_entries; i++) begin
            hit_index = hit_index | ({idx_w{match[i]}} & idx_w'(i));
        end
    end

    // and-or attribute select, a miss leaves all zeros
    always_comb begin
        hit_page = '0;
        for (int i = 0; i < num_entries; i++) begin
            hit_page = hit_page | ({page_w{match[i]}} & sel_page[i]);
        end
    end

    assign sif.found = |match;
    assign sif.index = hit_index;
    assign sif.page  = tlb_pkg::tlb_page_t'(hit_page);

    // software keeps keys unique across entries
    // holds once every entry has been written
    a_single_match: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(match)
    ) else $error("tlb lookup matched several entries: %b", match);

endmodule

// File: hw/tlb_pkg.sv
package tlb_pkg;

    // field widths of one entry
    localparam int vpn2_w  = 19;
    localparam int asid_w  = 8;
    localparam int pfn_w   = 20;
    localparam int cattr_w = 3;

    // one half of a page pair
    typedef struct packed {
        logic [pfn_w-1:0]   pfn;
        logic [cattr_w-1:0] c;
        logic               d;
        logic               v;
    } tlb_page_t;

    // full entry, 78 bits
    // page0 maps the even page, page1 the odd one
    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic [asid_w-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    // half of the pair that a lookup asks for
    typedef enum logic {
        page_even = 1'b0,
        page_odd  = 1'b1
    } page_sel_e;

endpackage

// File: hw/tlb_search_if.sv
`timescale 1ns/1ps

interface tlb_search_if #(
    parameter int num_entries = 16
);

    localparam int idx_w = $clog2(num_entries);

    // request
    logic [tlb_pkg::vpn2_w-1:0] vpn2;
    logic [tlb_pkg::asid_w-1:0] asid;
    tlb_pkg::page_sel_e         page_sel;

    // result, all zero on a miss
    logic                       found;
    logic [idx_w-1:0]           index;
    tlb_pkg::tlb_page_t         page;

    modport requester (
        output vpn2, asid, page_sel,
        input  found, index, page
    );

    modport responder (
        input  vpn2, asid, page_sel,
        output found, index, page
    );

endinterface

// File: tlb.f
hw/tlb_pkg.sv
hw/tlb_search_if.sv
hw/tlb_entry_array.sv
hw/tlb_lookup.sv
hw/tlb.sv
verif/tb_clock.sv
verif/tlb_tb.sv

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // synchronous reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: verif/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;

    localparam int num_entries     = 16;
    localparam int idx_w           = $clog2(num_entries);
    localparam int num_tests       = 5;
    localparam int cycles_per_test = 200;
    localparam int reset_cycles    = 10;

    typedef logic [tlb_pkg::vpn2_w-1:0] vpn2_t;
    typedef logic [tlb_pkg::asid_w-1:0] asid_t;

    typedef struct packed {
        logic               found;
        logic [idx_w-1:0]   index;
        tlb_pkg::tlb_page_t page;
    } result_t;

    // key that no written entry ever uses
    localparam vpn2_t idle_vpn2 = '1;

    logic clk;
    logic reset;

    logic                        we;
    logic [idx_w-1:0]            w_index;
    tlb_pkg::tlb_entry_t         w_entry;
    logic [idx_w-1:0]            r_index;
    wire tlb_pkg::tlb_entry_t    r_entry;

    // index 0 is search port 0, index 1 is port 1
    logic [1:0][tlb_pkg::vpn2_w-1:0] s_vpn2;
    logic [1:0][tlb_pkg::asid_w-1:0] s_asid;
    logic [1:0]                      s_odd;
    wire  [1:0]                      s_found;
    wire  [1:0][idx_w-1:0]           s_index;
    wire tlb_pkg::tlb_page_t [1:0]   s_page;

    tlb_pkg::tlb_entry_t model [num_entries];
    bit                  written [num_entries];
    int                  errors;
    int                  checks;

    tb_clock #(.half_period(10), .reset_cycles(reset_cycles)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    tlb #(.num_entries(num_entries)) DUT (
        .clk (clk), .reset (reset),
        .s0_vpn2 (s_vpn2[0]), .s0_odd_page (s_odd[0]), .s0_asid (s_asid[0]),
        .s0_found (s_found[0]), .s0_index (s_index[0]), .s0_pfn (s_page[0].pfn),
        .s0_c (s_page[0].c), .s0_d (s_page[0].d), .s0_v (s_page[0].v),
        .s1_vpn2 (s_vpn2[1]), .s1_odd_page (s_odd[1]), .s1_asid (s_asid[1]),
        .s1_found (s_found[1]), .s1_index (s_index[1]), .s1_pfn (s_page[1].pfn),
        .s1_c (s_page[1].c), .s1_d (s_page[1].d), .s1_v (s_page[1].v),
        .we (we), .w_index (w_index), .w_vpn2 (w_entry.vpn2), .w_asid (w_entry.asid),
        .w_g (w_entry.g), .w_pfn0 (w_entry.page0.pfn), .w_c0 (w_entry.page0.c),
        .w_d0 (w_entry.page0.d), .w_v0 (w_entry.page0.v), .w_pfn1 (w_entry.page1.pfn),
        .w_c1 (w_entry.page1.c), .w_d1 (w_entry.page1.d), .w_v1 (w_entry.page1.v),
        .r_index (r_index), .r_vpn2 (r_entry.vpn2), .r_asid (r_entry.asid), .r_g (r_entry.g),
        .r_pfn0 (r_entry.page0.pfn), .r_c0 (r_entry.page0.c), .r_d0 (r_entry.page0.d),
        .r_v0 (r_entry.page0.v), .r_pfn1 (r_entry.page1.pfn), .r_c1 (r_entry.page1.c),
        .r_d1 (r_entry.page1.d), .r_v1 (r_entry.page1.v)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // vpn2 not held by any written entry
    function automatic vpn2_t fresh_vpn2();
        logic [31:0] r;
        vpn2_t       v;
        bit          used;
        do begin
            r    = $urandom;
            v    = r[tlb_pkg::vpn2_w-1:0];
            used = (v == idle_vpn2);
            for (int i = 0; i < num_entries; i++) begin
                if (written[i] && model[i].vpn2 == v) begin
                    used = 1'b1;
                end
            end
        end while (used);
        return v;
    endfunction

    function automatic tlb_pkg::tlb_entry_t random_entry(input vpn2_t vpn2);
        tlb_pkg::tlb_entry_t e;
        logic [31:0]         r0;
        logic [31:0]         r1;
        logic [31:0]         r2;
        r0 = $urandom;
        r1 = $urandom;
        r2 = $urandom;
        e.vpn2      = vpn2;
        e.asid      = r0[7:0];
        e.g         = r0[8];
        e.page0.pfn = r1[19:0];
        e.page0.c   = r1[22:20];
        e.page0.d   = r1[23];
        e.page0.v   = r1[24];
        e.page1.pfn = r2[19:0];
        e.page1.c   = r2[22:20];
        e.page1.d   = r2[23];
        e.page1.v   = r2[24];
        return e;
    endfunction

    // match on vpn2, and on asid or g; zeros on a miss
    function automatic result_t model_search(input vpn2_t vpn2, input asid_t asid,
                                             input logic odd);
        result_t res;
        res = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (written[i] && model[i].vpn2 == vpn2 && (model[i].asid == asid || model[i].g)) begin
                res.found = 1'b1;
                res.index = idx_w'(i);
                res.page  = odd ? model[i].page1 : model[i].page0;
            end
        end
        return res;
    endfunction

    task automatic write_entry(input int idx, input tlb_pkg::tlb_entry_t e);
        @(posedge clk);
        we           <= 1'b1;
        w_index      <= idx_w'(idx);
        w_entry      <= e;
        model[idx]   = e;
        written[idx] = 1'b1;
    endtask

    // last write lands on this edge
    task automatic end_write();
        @(posedge clk);
        we <= 1'b0;
    endtask

    task automatic drive_search(input int p, input vpn2_t vpn2, input asid_t asid,
                                input logic odd);
        s_vpn2[p] <= vpn2;
        s_asid[p] <= asid;
        s_odd[p]  <= odd;
    endtask

    task automatic check_port(input int p, input logic want_hit);
        result_t exp;
        string   pre;
        exp = model_search(s_vpn2[p], s_asid[p], s_odd[p]);
        pre = (p == 0) ? "s0_" : "s1_";
        if (exp.found != want_hit) begin
            errors++;
            $display("test setup error at %0t ns: model disagrees with intended hit on port %0d",
                     $time, p);
        end
        check_value({pre, "found"}, 32'(want_hit), 32'(s_found[p]));
        check_value({pre, "index"}, 32'(exp.index), 32'(s_index[p]));
        check_value({pre, "pfn"}, 32'(exp.page.pfn), 32'(s_page[p].pfn));
        check_value({pre, "c"}, 32'(exp.page.c), 32'(s_page[p].c));
        check_value({pre, "d"}, 32'(exp.page.d), 32'(s_page[p].d));
        check_value({pre, "v"}, 32'(exp.page.v), 32'(s_page[p].v));
    endtask

    task automatic check_read(input int idx);
        tlb_pkg::tlb_entry_t exp;
        exp = model[idx];
        check_value("r_vpn2", 32'(exp.vpn2), 32'(r_entry.vpn2));
        check_value("r_asid", 32'(exp.asid), 32'(r_entry.asid));
        check_value("r_g", 32'(exp.g), 32'(r_entry.g));
        check_value("r_pfn0", 32'(exp.page0.pfn), 32'(r_entry.page0.pfn));
        check_value("r_c0", 32'(exp.page0.c), 32'(r_entry.page0.c));
        check_value("r_d0", 32'(exp.page0.d), 32'(r_entry.page0.d));
        check_value("r_v0", 32'(exp.page0.v), 32'(r_entry.page0.v));
        check_value("r_pfn1", 32'(exp.page1.pfn), 32'(r_entry.page1.pfn));
        check_value("r_c1", 32'(exp.page1.c), 32'(r_entry.page1.c));
        check_value("r_d1", 32'(exp.page1.d), 32'(r_entry.page1.d));
        check_value("r_v1", 32'(exp.page1.v), 32'(r_entry.page1.v));
    endtask

    task automatic test_write_read();
        for (int i = 0; i < num_entries; i++) begin
            write_entry(i, random_entry(fresh_vpn2()));
        end
        end_write();
        for (int i = 0; i < num_entries; i++) begin
            @(posedge clk);
            r_index <= idx_w'(i);
            @(negedge clk);
            check_read(i);
        end
    endtask

    task automatic test_lookup_hit();
        for (int i = 0; i < num_entries; i++) begin
            for (int odd = 0; odd < 2; odd++) begin
                @(posedge clk);
                drive_search(0, model[i].vpn2, model[i].asid, 1'(odd));
                @(negedge clk);
                check_port(0, 1'b1);
            end
        end
    endtask

    task automatic test_global();
        tlb_pkg::tlb_entry_t e;
        int                  idx;
        e   = random_entry(model[3].vpn2);
        e.g = 1'b1;
        write_entry(3, e);
        e   = random_entry(model[9].vpn2);
        e.g = 1'b0;
        write_entry(9, e);
        end_write();
        for (int k = 0; k < 2; k++) begin
            idx = (k == 0) ? 3 : 9;
            @(posedge clk);
            drive_search(0, model[idx].vpn2, model[idx].asid + 8'd1, 1'(k));
            @(negedge clk);
            check_port(0, idx == 3);
        end
    endtask

    task automatic test_overwrite();
        tlb_pkg::tlb_entry_t e;
        vpn2_t               old_vpn2;
        old_vpn2 = model[5].vpn2;
        e        = random_entry(fresh_vpn2());
        write_entry(5, e);
        end_write();
        @(posedge clk);
        drive_search(0, old_vpn2, e.asid, 1'b0);
        drive_search(1, e.vpn2, e.asid, 1'b1);
        @(negedge clk);
        check_port(0, 1'b0);
        check_port(1, 1'b1);
        check_value("s1_index", 32'd5, 32'(s_index[1]));
    endtask

    task automatic test_ports();
        int    a;
        int    b;
        vpn2_t miss_vpn2;
        a         = int'($urandom_range(0, num_entries - 1));
        b         = (a + 1 + int'($urandom_range(0, num_entries - 2))) % num_entries;
        miss_vpn2 = fresh_vpn2();
        // hit and hit
        @(posedge clk);
        drive_search(0, model[a].vpn2, model[a].asid, 1'b0);
        drive_search(1, model[b].vpn2, model[b].asid, 1'b1);
        @(negedge clk);
        check_port(0, 1'b1);
        check_port(1, 1'b1);
        // hit and miss
        @(posedge clk);
        drive_search(0, model[b].vpn2, model[b].asid, 1'b1);
        drive_search(1, miss_vpn2, model[a].asid, 1'b0);
        @(negedge clk);
        check_port(0, 1'b1);
        check_port(1, 1'b0);
        // miss and hit
        @(posedge clk);
        drive_search(0, miss_vpn2, model[b].asid, 1'b0);
        drive_search(1, model[a].vpn2, model[a].asid, 1'b1);
        @(negedge clk);
        check_port(0, 1'b0);
        check_port(1, 1'b1);
    endtask

    initial begin
        repeat (reset_cycles + num_tests * cycles_per_test) @(posedge clk);
        $display("timeout: tests still running after %0d cycles",
                 reset_cycles + num_tests * cycles_per_test);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(68286));
        errors   = 0;
        checks   = 0;
        we       = 1'b0;
        w_index  = '0;
        w_entry  = '0;
        r_index  = '0;
        s_vpn2   = {2{idle_vpn2}};
        s_asid   = '0;
        s_odd    = '0;
        for (int i = 0; i < num_entries; i++) begin
            written[i] = 1'b0;
        end
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        test_write_read();
        test_lookup_hit();
        test_global();
        test_overwrite();
        test_ports();
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
